/* hdl/rename_consts.svh */
`ifndef RENAME_CONSTS_SVH
`define RENAME_CONSTS_SVH

// machine widths
`define ISSUE_W     2       // lanes per group
`define RET_W       2       // retire bus entries
`define XLEN        32
`define REG_IDX_W   5
`define NUM_REGS    32
`define ROB_ID_W    5
`define TAG_W       ((`REG_IDX_W > `ROB_ID_W) ? `REG_IDX_W : `ROB_ID_W)
`define NUM_SRCS    2       // rs1, rs2

// rv32 opcodes
`define OPC_JALR    7'b1100111
`define OPC_LOAD    7'b0000011
`define OPC_OP_IMM  7'b0010011
`define OPC_STORE   7'b0100011
`define OPC_BRANCH  7'b1100011
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111
`define OPC_JAL     7'b1101111
`define OPC_OP      7'b0110011

// func3 / func7
`define F3_ADD      3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SR       3'b101  // srl / sra
`define F3_OR       3'b110
`define F3_AND      3'b111
`define FUNC7_ALT   7'b0100000
`define FUNC7_MULDIV 7'b0000001

// functional unit lane masks, one-hot
`define LANE_ALU    4'b0001
`define LANE_MUL    4'b0010
`define LANE_MEM    4'b0100
`define LANE_BR     4'b1000

`endif

/* hdl/rename_pkg.sv */
package rename_pkg;

    `include "rename_consts.svh"

    typedef logic [`REG_IDX_W-1:0] reg_idx_t;
    typedef logic [`ROB_ID_W-1:0]  rob_id_t;
    typedef logic [`TAG_W-1:0]     tag_t;

    ////////////////////////////////////////
    // instruction formats
    ////////////////////////////////////////

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one word, six views
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_word_u;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_LT, ALU_XOR, ALU_OR,
        ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA, ALU_PASS
    } alu_op_e;

    ////////////////////////////////////////
    // stage bundles
    ////////////////////////////////////////

    typedef struct packed {
        logic        valid;     // single-cycle strobe
        instr_word_u instr;
        rob_id_t     rob_id;
    } id_in_t;

    typedef struct packed {
        logic       alu_src;    // 1: immediate as op2
        logic [3:0] fu_dest;    // lane mask
        alu_op_e    alu_op;
        logic       mem_read;
        logic       mem_write;
        logic       rf_write;
        logic [2:0] func3;
    } ctrl_t;

    typedef struct packed {
        logic                           valid;
        logic [6:0]                     opcode;
        reg_idx_t                       rd;
        reg_idx_t [`NUM_SRCS-1:0]       rs;
        logic [`XLEN-1:0]               imm;
        ctrl_t                          ctrl;
        rob_id_t                        rob_id;
    } dec_t;

    typedef struct packed {
        logic is_prf;   // 1: register file, 0: rob
        tag_t tag;      // reg index or rob id
    } src_t;

    typedef struct packed {
        logic     valid;
        logic     rf_write;
        reg_idx_t rd;
        rob_id_t  rob_id;
    } ret_t;

    typedef struct packed {
        dec_t                   dec;
        src_t [`NUM_SRCS-1:0]   src;
    } ar_out_t;

endpackage

/* hdl/instr_decoder.sv */
`timescale 1ns/1ns
`include "rename_consts.svh"

module instr_decoder import rename_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  id_in_t [`ISSUE_W-1:0]   id_in,
    output dec_t   [`ISSUE_W-1:0]   dec_id
);

    // func3 -> alu op, alt picks sra and (reg form only) sub
    function automatic alu_op_e f3_to_alu(input logic [2:0] f3, input logic alt,
                                          input logic is_reg);
        alu_op_e op;
        case (f3)
            `F3_ADD:           op = (alt && is_reg) ? ALU_SUB : ALU_ADD;
            `F3_SLL:           op = ALU_SLL;
            `F3_SLT, `F3_SLTU: op = ALU_LT;      // signedness left to func3
            `F3_XOR:           op = ALU_XOR;
            `F3_SR:            op = alt ? ALU_SRA : ALU_SRL;
            `F3_OR:            op = ALU_OR;
            `F3_AND:           op = ALU_AND;
            default:           op = ALU_ADD;
        endcase
        return op;
    endfunction

    always_comb begin
        instr_word_u w;
        logic        alt;
        for (int i = 0; i < `ISSUE_W; i++) begin
            w   = id_in[i].instr;
            alt = (w.r.funct7 == `FUNC7_ALT);   // same bits as imm[11:5]

            dec_id[i].valid  = id_in[i].valid;
            dec_id[i].opcode = w.r.opcode;
            dec_id[i].rd     = w.r.rd;
            dec_id[i].rs[0]  = w.r.rs1;
            dec_id[i].rs[1]  = w.r.rs2;
            dec_id[i].rob_id = id_in[i].rob_id;

            ////////////////////////////////////////
            // immediate, sign bit is instr[31]
            ////////////////////////////////////////
            case (w.r.opcode)
                `OPC_JALR, `OPC_LOAD, `OPC_OP_IMM:
                    dec_id[i].imm = {{20{w.i.imm[11]}}, w.i.imm};
                `OPC_STORE:
                    dec_id[i].imm = {{20{w.s.imm_11_5[6]}}, w.s.imm_11_5, w.s.imm_4_0};
                `OPC_BRANCH:
                    dec_id[i].imm = {{19{w.b.imm_12}}, w.b.imm_12, w.b.imm_11,
                                     w.b.imm_10_5, w.b.imm_4_1, 1'b0};
                `OPC_LUI, `OPC_AUIPC:
                    dec_id[i].imm = {w.u.imm_31_12, 12'b0};
                `OPC_JAL:
                    dec_id[i].imm = {{11{w.j.imm_20}}, w.j.imm_20, w.j.imm_19_12,
                                     w.j.imm_11, w.j.imm_10_1, 1'b0};
                default:
                    dec_id[i].imm = '0;
            endcase

            ////////////////////////////////////////
            // control bundle
            ////////////////////////////////////////
            dec_id[i].ctrl           = '0;      // unknown opcode -> all off, add
            dec_id[i].ctrl.alu_op    = ALU_ADD;
            dec_id[i].ctrl.func3     = w.r.funct3;   // branch cond, load size etc
            case (w.r.opcode)
                `OPC_JALR, `OPC_JAL: begin
                    dec_id[i].ctrl.alu_src  = 1'b1;
                    dec_id[i].ctrl.fu_dest  = `LANE_BR;
                    dec_id[i].ctrl.rf_write = 1'b1;    // link reg
                end
                `OPC_LOAD: begin
                    dec_id[i].ctrl.alu_src  = 1'b1;
                    dec_id[i].ctrl.fu_dest  = `LANE_MEM;
                    dec_id[i].ctrl.mem_read = 1'b1;
                    dec_id[i].ctrl.rf_write = 1'b1;
                end
                `OPC_STORE: begin
                    dec_id[i].ctrl.alu_src   = 1'b1;
                    dec_id[i].ctrl.fu_dest   = `LANE_MEM;
                    dec_id[i].ctrl.mem_write = 1'b1;
                end
                `OPC_BRANCH: begin
                    dec_id[i].ctrl.fu_dest = `LANE_BR;
                    dec_id[i].ctrl.alu_op  = ALU_SUB;  // compare
                end
                `OPC_OP_IMM: begin
                    dec_id[i].ctrl.alu_src  = 1'b1;
                    dec_id[i].ctrl.fu_dest  = `LANE_ALU;
                    dec_id[i].ctrl.alu_op   = f3_to_alu(w.i.funct3, alt, 1'b0);
                    dec_id[i].ctrl.rf_write = 1'b1;
                end
                `OPC_OP: begin
                    dec_id[i].ctrl.rf_write = 1'b1;
                    if (w.r.funct7 == `FUNC7_MULDIV) begin
                        dec_id[i].ctrl.fu_dest = `LANE_MUL;
                    end else begin
                        dec_id[i].ctrl.fu_dest = `LANE_ALU;
                        dec_id[i].ctrl.alu_op  = f3_to_alu(w.r.funct3, alt, 1'b1);
                    end
                end
                `OPC_LUI, `OPC_AUIPC: begin
                    dec_id[i].ctrl.alu_src  = 1'b1;
                    dec_id[i].ctrl.fu_dest  = `LANE_ALU;
                    dec_id[i].ctrl.alu_op   = ALU_PASS;  // imm straight through
                    dec_id[i].ctrl.rf_write = 1'b1;
                end
                default: ;
            endcase
        end
    end

    // groups fill from lane 0 upward
    a_lane_order: assert property (@(posedge clk) disable iff (rst)
        id_in[1].valid |-> id_in[0].valid);

endmodule

/* hdl/alias_table.sv */
`timescale 1ns/1ns
`include "rename_consts.svh"

module alias_table import rename_pkg::*; (
    input  logic                                clk,
    input  logic                                rst,
    input  dec_t [`ISSUE_W-1:0]                 dec_id,
    input  ret_t [`RET_W-1:0]                   ret,
    output src_t [`ISSUE_W-1:0][`NUM_SRCS-1:0]  src_map_ar
);

    src_t [`NUM_REGS-1:0] rat;          // arch reg -> {is_prf, tag}

    logic [`ISSUE_W-1:0] iss_wr;        // issue lane writes its rd
    logic [`RET_W-1:0]   ret_wr;        // retire entry restores its rd

    ////////////////////////////////////////
    // write enables
    ////////////////////////////////////////
    always_comb begin
        logic clash;
        for (int i = 0; i < `ISSUE_W; i++) begin
            iss_wr[i] = dec_id[i].valid && dec_id[i].ctrl.rf_write && (dec_id[i].rd != '0);
        end
        for (int r = 0; r < `RET_W; r++) begin
            clash = 1'b0;
            for (int i = 0; i < `ISSUE_W; i++) begin
                clash |= iss_wr[i] && (dec_id[i].rd == ret[r].rd);   // issue wins
            end
            // only if the table still points at this rob id
            ret_wr[r] = ret[r].valid && ret[r].rf_write && (ret[r].rd != '0)
                        && !rat[ret[r].rd].is_prf
                        && (rat[ret[r].rd].tag == tag_t'(ret[r].rob_id))
                        && !clash;
        end
    end

    ////////////////////////////////////////
    // table update, later writes win
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < `NUM_REGS; k++) begin
                rat[k] <= '{is_prf: 1'b1, tag: tag_t'(k)};   // identity map
            end
        end else begin
            for (int r = 0; r < `RET_W; r++) begin
                if (ret_wr[r]) begin
                    rat[ret[r].rd] <= '{is_prf: 1'b1, tag: tag_t'(ret[r].rd)};
                end
            end
            // lane order gives lane 1 priority on same rd
            for (int i = 0; i < `ISSUE_W; i++) begin
                if (iss_wr[i]) begin
                    rat[dec_id[i].rd] <= '{is_prf: 1'b0, tag: tag_t'(dec_id[i].rob_id)};
                end
            end
        end
    end

    // source read, sees table from before this edge
    always_ff @(posedge clk) begin
        for (int i = 0; i < `ISSUE_W; i++) begin
            if (dec_id[i].valid) begin
                for (int s = 0; s < `NUM_SRCS; s++) begin
                    src_map_ar[i][s] <= rat[dec_id[i].rs[s]];
                end
            end
        end
    end

    // x0 never renamed
    a_x0_prf: assert property (@(posedge clk) disable iff (rst)
        rat[0].is_prf && (rat[0].tag == '0));

endmodule

/* hdl/dep_resolver.sv */
`timescale 1ns/1ns
`include "rename_consts.svh"

module dep_resolver import rename_pkg::*; (
    input  logic                                clk,
    input  logic                                rst,
    input  dec_t [`ISSUE_W-1:0]                 dec_id,
    input  src_t [`ISSUE_W-1:0][`NUM_SRCS-1:0]  src_map_ar,
    input  ret_t [`RET_W-1:0]                   ret,
    output ar_out_t [`ISSUE_W-1:0]              ar_out
);

    localparam int RSEL_W = $clog2(`RET_W);

    dec_t [`ISSUE_W-1:0] dec_ar;
    ret_t [`RET_W-1:0]   ret_ar;        // retire bus seen during id

    logic [`ISSUE_W-1:0]                              wr_ar;
    logic [`ISSUE_W-1:0][`NUM_SRCS-1:0][`ISSUE_W-1:0] grp_hit;   // older lane writes src
    logic [`ISSUE_W-1:0][`NUM_SRCS-1:0][`RET_W-1:0]   prev_hit;  // retired during id read
    logic [`ISSUE_W-1:0][`NUM_SRCS-1:0][`RET_W-1:0]   live_hit;  // retiring now
    logic                                             ret_dup;

    // lowest set bit wins
    function automatic logic [RSEL_W-1:0] prio_enc(input logic [`RET_W-1:0] hit);
        logic [RSEL_W-1:0] idx;
        idx = '0;
        for (int r = `RET_W-1; r >= 0; r--) begin
            if (hit[r]) idx = RSEL_W'(r);
        end
        return idx;
    endfunction

    ////////////////////////////////////////
    // id/ar pipeline register
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        dec_ar <= dec_id;
        ret_ar <= ret;
        if (rst) begin
            for (int i = 0; i < `ISSUE_W; i++) dec_ar[i].valid <= 1'b0;
            for (int r = 0; r < `RET_W; r++)   ret_ar[r].valid <= 1'b0;
        end
    end

    always_comb begin
        for (int i = 0; i < `ISSUE_W; i++) begin
            wr_ar[i] = dec_ar[i].valid && dec_ar[i].ctrl.rf_write && (dec_ar[i].rd != '0);
        end
        grp_hit  = '0;
        prev_hit = '0;
        live_hit = '0;
        for (int i = 0; i < `ISSUE_W; i++) begin
            for (int s = 0; s < `NUM_SRCS; s++) begin
                for (int j = 0; j < i; j++) begin
                    grp_hit[i][s][j] = wr_ar[j] && (dec_ar[i].rs[s] == dec_ar[j].rd);
                end
                for (int r = 0; r < `RET_W; r++) begin
                    prev_hit[i][s][r] = !src_map_ar[i][s].is_prf && ret_ar[r].valid
                        && (src_map_ar[i][s].tag == tag_t'(ret_ar[r].rob_id));
                    live_hit[i][s][r] = !src_map_ar[i][s].is_prf && ret[r].valid
                        && (src_map_ar[i][s].tag == tag_t'(ret[r].rob_id));
                end
            end
        end
    end

    ////////////////////////////////////////
    // source overrides, first rule wins
    ////////////////////////////////////////
    always_comb begin
        for (int i = 0; i < `ISSUE_W; i++) begin
            ar_out[i].dec = dec_ar[i];
            for (int s = 0; s < `NUM_SRCS; s++) begin
                if (|grp_hit[i][s]) begin
                    ar_out[i].src[s] = '{is_prf: 1'b0, tag: '0};
                    for (int j = 0; j < i; j++) begin     // youngest older writer
                        if (grp_hit[i][s][j]) ar_out[i].src[s].tag = tag_t'(dec_ar[j].rob_id);
                    end
                end else if (|prev_hit[i][s]) begin
                    ar_out[i].src[s] = '{is_prf: 1'b1,
                        tag: tag_t'(ret_ar[prio_enc(prev_hit[i][s])].rd)};
                end else if (|live_hit[i][s]) begin
                    ar_out[i].src[s] = '{is_prf: 1'b1,
                        tag: tag_t'(ret[prio_enc(live_hit[i][s])].rd)};
                end else begin
                    ar_out[i].src[s] = src_map_ar[i][s];  // table value stands
                end
            end
        end
    end

    // rob retires each id once
    always_comb begin
        ret_dup = 1'b0;
        for (int a = 0; a < `RET_W; a++) begin
            for (int b = a + 1; b < `RET_W; b++) begin
                ret_dup |= ret[a].valid && ret[b].valid && (ret[a].rob_id == ret[b].rob_id);
            end
        end
    end

    a_ret_unique: assert property (@(posedge clk) disable iff (rst) !ret_dup);

endmodule

/* hdl/rename_top.sv */
`timescale 1ns/1ns
`include "rename_consts.svh"

module rename_top import rename_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  id_in_t  [`ISSUE_W-1:0]  id_in,
    input  ret_t    [`RET_W-1:0]    ret,
    output ar_out_t [`ISSUE_W-1:0]  ar_out
);

    dec_t [`ISSUE_W-1:0]                dec_id;      // id stage, combinational
    src_t [`ISSUE_W-1:0][`NUM_SRCS-1:0] src_map_ar;  // table read, ar stage

    ////////////////////////////////////////
    // id stage
    ////////////////////////////////////////
    instr_decoder u_decoder (
        .clk    (clk),
        .rst    (rst),
        .id_in  (id_in),
        .dec_id (dec_id)
    );

    alias_table u_rat (
        .clk        (clk),
        .rst        (rst),
        .dec_id     (dec_id),
        .ret        (ret),
        .src_map_ar (src_map_ar)
    );

    ////////////////////////////////////////
    // ar stage
    ////////////////////////////////////////
    dep_resolver u_resolver (
        .clk        (clk),
        .rst        (rst),
        .dec_id     (dec_id),
        .src_map_ar (src_map_ar),
        .ret        (ret),
        .ar_out     (ar_out)
    );

endmodule

/* sim/rename_checker.sv */
`timescale 1ns/1ns
`include "rename_consts.svh"

module rename_checker import rename_pkg::*; (
    input logic                    clk,
    input logic                    rst,
    input id_in_t  [`ISSUE_W-1:0]  id_in,
    input ret_t    [`RET_W-1:0]    ret,
    input ar_out_t [`ISSUE_W-1:0]  ar_out
);

    src_t [`NUM_REGS-1:0]               rat_m;      // model alias table
    src_t [`NUM_REGS-1:0]               rat_nxt;
    dec_t [`ISSUE_W-1:0]                exp_dec;    // group now in ar
    dec_t [`ISSUE_W-1:0]                new_dec;
    src_t [`ISSUE_W-1:0][`NUM_SRCS-1:0] exp_map;    // table read for that group
    ret_t [`RET_W-1:0]                  ret_prev;   // retire bus of the id cycle
    logic [`ISSUE_W-1:0]                iss_m;

    int err_cnt      = 0;
    int test_err     = 0;
    int checks       = 0;
    int tests_run    = 0;
    int tests_failed = 0;

    ////////////////////////////////////////
    // reference decode
    ////////////////////////////////////////
    function automatic alu_op_e alu_ref(input logic [2:0] f3, input logic alt, input logic is_op);
        case (f3)
            3'b000:         return (alt && is_op) ? ALU_SUB : ALU_ADD;
            3'b001:         return ALU_SLL;
            3'b010, 3'b011: return ALU_LT;
            3'b100:         return ALU_XOR;
            3'b101:         return alt ? ALU_SRA : ALU_SRL;
            3'b110:         return ALU_OR;
            default:        return ALU_AND;
        endcase
    endfunction

    function automatic dec_t decode_ref(input logic v, input logic [31:0] w, input rob_id_t id);
        dec_t       d;
        logic [6:0] opc;
        logic       alt;
        opc         = w[6:0];
        alt         = (w[31:25] == 7'b0100000);
        d.valid     = v;
        d.opcode    = opc;
        d.rd        = w[11:7];
        d.rs[0]     = w[19:15];
        d.rs[1]     = w[24:20];
        d.rob_id    = id;
        d.ctrl      = '0;
        d.ctrl.alu_op = ALU_ADD;
        d.ctrl.func3  = w[14:12];
        case (opc)
            `OPC_JALR, `OPC_LOAD, `OPC_OP_IMM: d.imm = {{20{w[31]}}, w[31:20]};
            `OPC_STORE:  d.imm = {{20{w[31]}}, w[31:25], w[11:7]};
            `OPC_BRANCH: d.imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            `OPC_LUI, `OPC_AUIPC: d.imm = {w[31:12], 12'h000};
            `OPC_JAL:    d.imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            default:     d.imm = '0;
        endcase
        case (opc)
            `OPC_JALR, `OPC_JAL: begin
                d.ctrl.alu_src  = 1'b1;
                d.ctrl.fu_dest  = 4'b1000;
                d.ctrl.rf_write = 1'b1;
            end
            `OPC_LOAD: begin
                d.ctrl.alu_src  = 1'b1;
                d.ctrl.fu_dest  = 4'b0100;
                d.ctrl.mem_read = 1'b1;
                d.ctrl.rf_write = 1'b1;
            end
            `OPC_STORE: begin
                d.ctrl.alu_src   = 1'b1;
                d.ctrl.fu_dest   = 4'b0100;
                d.ctrl.mem_write = 1'b1;
            end
            `OPC_BRANCH: begin
                d.ctrl.fu_dest = 4'b1000;
                d.ctrl.alu_op  = ALU_SUB;
            end
            `OPC_OP_IMM: begin
                d.ctrl.alu_src  = 1'b1;
                d.ctrl.fu_dest  = 4'b0001;
                d.ctrl.alu_op   = alu_ref(w[14:12], alt, 1'b0);
                d.ctrl.rf_write = 1'b1;
            end
            `OPC_OP: begin
                d.ctrl.rf_write = 1'b1;
                d.ctrl.fu_dest  = (w[31:25] == 7'b0000001) ? 4'b0010 : 4'b0001;
                if (w[31:25] != 7'b0000001) d.ctrl.alu_op = alu_ref(w[14:12], alt, 1'b1);
            end
            `OPC_LUI, `OPC_AUIPC: begin
                d.ctrl.alu_src  = 1'b1;
                d.ctrl.fu_dest  = 4'b0001;
                d.ctrl.alu_op   = ALU_PASS;
                d.ctrl.rf_write = 1'b1;
            end
            default: ;
        endcase
        return d;
    endfunction

    function automatic logic writes_rd(input dec_t d);
        return d.valid && d.ctrl.rf_write && (d.rd != '0);
    endfunction

    // expected ar source, first rule that matches
    function automatic src_t resolve_src(input int i, input int s);
        src_t t;
        t = exp_map[i][s];
        if (i == 1 && writes_rd(exp_dec[0]) && exp_dec[1].rs[s] == exp_dec[0].rd)
            return '{is_prf: 1'b0, tag: exp_dec[0].rob_id};
        if (t.is_prf) return t;
        for (int r = 0; r < `RET_W; r++)
            if (ret_prev[r].valid && ret_prev[r].rob_id == t.tag)
                return '{is_prf: 1'b1, tag: ret_prev[r].rd};
        for (int r = 0; r < `RET_W; r++)
            if (ret[r].valid && ret[r].rob_id == t.tag)
                return '{is_prf: 1'b1, tag: ret[r].rd};
        return t;
    endfunction

    function automatic void flag(input string what, input logic [127:0] exp, input logic [127:0] act);
        $display("FAIL %s expected %h actual %h at %0t", what, exp, act, $time);
        err_cnt++;
        test_err++;
    endfunction

    ////////////////////////////////////////
    // compare, then advance the model
    ////////////////////////////////////////
    always @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < `NUM_REGS; k++) rat_m[k] = '{is_prf: 1'b1, tag: k[4:0]};
            for (int i = 0; i < `ISSUE_W; i++) exp_dec[i].valid = 1'b0;
            ret_prev = '0;
        end else begin
            for (int i = 0; i < `ISSUE_W; i++) begin
                checks++;
                if (ar_out[i].dec.valid !== exp_dec[i].valid)
                    flag($sformatf("ar_out[%0d].dec.valid", i), exp_dec[i].valid,
                         ar_out[i].dec.valid);
                else if (exp_dec[i].valid) begin
                    if (ar_out[i].dec !== exp_dec[i])
                        flag($sformatf("ar_out[%0d].dec", i), exp_dec[i], ar_out[i].dec);
                    for (int s = 0; s < `NUM_SRCS; s++)
                        if (ar_out[i].src[s] !== resolve_src(i, s))
                            flag($sformatf("ar_out[%0d].src[%0d]", i, s), resolve_src(i, s),
                                 ar_out[i].src[s]);
                end
            end
            // capture this id cycle
            for (int i = 0; i < `ISSUE_W; i++) begin
                new_dec[i] = decode_ref(id_in[i].valid, id_in[i].instr, id_in[i].rob_id);
                iss_m[i]   = writes_rd(new_dec[i]);
                for (int s = 0; s < `NUM_SRCS; s++)
                    if (new_dec[i].valid) exp_map[i][s] = rat_m[new_dec[i].rs[s]];
            end
            rat_nxt = rat_m;
            for (int r = 0; r < `RET_W; r++)
                if (ret[r].valid && ret[r].rf_write && ret[r].rd != '0
                    && !rat_m[ret[r].rd].is_prf && rat_m[ret[r].rd].tag == ret[r].rob_id
                    && !(iss_m[0] && new_dec[0].rd == ret[r].rd)
                    && !(iss_m[1] && new_dec[1].rd == ret[r].rd))
                    rat_nxt[ret[r].rd] = '{is_prf: 1'b1, tag: ret[r].rd};
            for (int i = 0; i < `ISSUE_W; i++)     // lane 1 last, so it wins
                if (iss_m[i]) rat_nxt[new_dec[i].rd] = '{is_prf: 1'b0, tag: new_dec[i].rob_id};
            rat_m    = rat_nxt;
            exp_dec  = new_dec;
            ret_prev = ret;
        end
    end

    task automatic end_test(input string name);
        tests_run++;
        if (test_err == 0) begin
            $display("test %-10s ok     (%0d lane checks)", name, checks);
        end else begin
            tests_failed++;
            $display("test %-10s FAILED (%0d errors)", name, test_err);
        end
        test_err = 0;
        checks   = 0;
    endtask

    task automatic report();
        $display("tests run %0d, passed %0d, failed %0d, value errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, err_cnt);
    endtask

endmodule

/* sim/rename_tb.sv */
`timescale 1ns/1ns
`include "rename_consts.svh"

module rename_tb import rename_pkg::*; ();

    logic                    clk;
    logic                    rst;
    id_in_t  [`ISSUE_W-1:0]  id_in;
    ret_t    [`RET_W-1:0]    ret;
    ar_out_t [`ISSUE_W-1:0]  ar_out;

    integer      seed = 32;
    rob_id_t     next_rob;
    ret_t        inflight[$];   // issued but unretired ids in age order
    int          other_err = 0;
    logic [6:0]  opcs[10];

    initial clk = 1'b0;
    always #2 clk = ~clk;

    rename_top DUT (.clk(clk), .rst(rst), .id_in(id_in), .ret(ret), .ar_out(ar_out));

    rename_checker u_checker (.clk(clk), .rst(rst), .id_in(id_in), .ret(ret), .ar_out(ar_out));

    function automatic logic [31:0] i_instr(input logic [11:0] imm, input logic [4:0] rs1,
                                            input logic [4:0] rd, input logic [6:0] opc);
        return {imm, rs1, 3'b000, rd, opc};
    endfunction

    function automatic logic [31:0] r_instr(input logic [4:0] rs2, input logic [4:0] rs1,
                                            input logic [4:0] rd);
        return {7'b0000000, rs2, rs1, 3'b000, rd, `OPC_OP};
    endfunction

    function automatic logic has_rd(input logic [6:0] opc);
        return opc inside {`OPC_JALR, `OPC_JAL, `OPC_LOAD, `OPC_OP_IMM, `OPC_OP,
                           `OPC_LUI, `OPC_AUIPC};
    endfunction

    // drives one group on the falling edge and retires up to nret oldest ids
    task automatic drive_group(input logic v0, input logic [31:0] w0,
                               input logic v1, input logic [31:0] w1, input int nret);
        logic [31:0] w[2];
        logic        v[2];
        w[0] = w0;
        w[1] = w1;
        v[0] = v0;
        v[1] = v0 && v1;
        @(negedge clk);
        ret = '0;
        for (int r = 0; r < nret && inflight.size() > 0; r++) ret[r] = inflight.pop_front();
        for (int i = 0; i < `ISSUE_W; i++) begin
            id_in[i].valid  = v[i];
            id_in[i].instr  = w[i];
            id_in[i].rob_id = next_rob;
            if (v[i]) begin
                inflight.push_back('{valid: 1'b1, rf_write: has_rd(w[i][6:0]),
                                     rd: w[i][11:7], rob_id: next_rob});
                next_rob++;     // wraps mod 32
            end
        end
    endtask

    task automatic idle(input int nret);
        drive_group(1'b0, '0, 1'b0, '0, nret);
    endtask

    task automatic drain();
        int t;
        t = 0;
        while (inflight.size() > 0 && t < 64) begin
            idle(2);
            t++;
        end
        if (inflight.size() > 0) begin
            $display("timeout: retire queue did not drain");
            other_err++;
        end
        idle(0);
        idle(0);
    endtask

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////
    initial begin
        logic [31:0] w0;
        logic [31:0] w1;
        logic        v0;
        opcs = '{`OPC_JALR, `OPC_LOAD, `OPC_OP_IMM, `OPC_STORE, `OPC_BRANCH,
                 `OPC_LUI, `OPC_AUIPC, `OPC_JAL, `OPC_OP, 7'b0001111};
        rst      = 1'b1;
        id_in    = '0;
        // live writers held in id during reset, none may leak into ar or the table
        id_in[0].valid = 1'b1;
        id_in[0].instr = i_instr(12'd0, 5'd0, 5'd1, `OPC_OP_IMM);
        id_in[1].valid = 1'b1;
        id_in[1].instr = i_instr(12'd0, 5'd0, 5'd2, `OPC_OP_IMM);
        ret      = '0;
        next_rob = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst   = 1'b0;
        id_in = '0;

        idle(0);
        drive_group(1'b1, r_instr(5'd2, 5'd1, 5'd3), 1'b0, '0, 0);
        drain();
        u_checker.end_test("reset");

        for (int k = 0; k < 11; k++) begin
            w0 = $random(seed);
            w1 = $random(seed);
            w0[6:0] = opcs[k % 10];
            w1[6:0] = opcs[(k + 3) % 10];
            if (k == 9) begin
                w0[6:0]   = `OPC_OP;        // reg form sub
                w0[14:12] = 3'b000;
                w0[31:25] = `FUNC7_ALT;
                w1[14:12] = 3'b101;         // lane 1 is op-imm here, srai
                w1[31:25] = `FUNC7_ALT;
            end
            if (k == 10) begin
                w0[6:0]   = `OPC_OP;
                w0[31:25] = `FUNC7_MULDIV;  // mul/div
            end
            drive_group(1'b1, w0, 1'b1, w1, 2);
        end
        drain();
        u_checker.end_test("decode");

        drive_group(1'b1, i_instr(12'd4, 5'd1, 5'd5, `OPC_OP_IMM), 1'b0, '0, 0);
        drive_group(1'b1, r_instr(5'd0, 5'd5, 5'd6), 1'b1,
                    i_instr(12'd1, 5'd5, 5'd6, `OPC_OP_IMM), 0);
        drive_group(1'b1, r_instr(5'd0, 5'd6, 5'd0), 1'b1, r_instr(5'd0, 5'd0, 5'd4), 0);
        drain();
        u_checker.end_test("chain");

        drive_group(1'b1, i_instr(12'd8, 5'd1, 5'd7, `OPC_OP_IMM), 1'b1,
                    r_instr(5'd7, 5'd7, 5'd8), 0);
        drive_group(1'b1, {7'd0, 5'd2, 5'd1, 3'b010, 5'd12, `OPC_STORE}, 1'b1,
                    r_instr(5'd12, 5'd12, 5'd13), 0);
        drive_group(1'b1, {7'd0, 5'd2, 5'd1, 3'b000, 5'd14, `OPC_BRANCH}, 1'b1,
                    r_instr(5'd14, 5'd1, 5'd15), 0);
        drain();
        u_checker.end_test("intra");

        drive_group(1'b1, i_instr(12'd1, 5'd1, 5'd9, `OPC_OP_IMM), 1'b0, '0, 0);
        idle(0);
        idle(1);
        drive_group(1'b1, r_instr(5'd0, 5'd9, 5'd1), 1'b0, '0, 0);
        drain();
        drive_group(1'b1, i_instr(12'd2, 5'd1, 5'd9, `OPC_OP_IMM), 1'b0, '0, 0);
        drive_group(1'b1, r_instr(5'd9, 5'd9, 5'd2), 1'b0, '0, 1);   // retire in id
        drain();
        drive_group(1'b1, i_instr(12'd3, 5'd1, 5'd10, `OPC_OP_IMM), 1'b0, '0, 0);
        drive_group(1'b1, r_instr(5'd0, 5'd10, 5'd2), 1'b0, '0, 0);
        idle(1);                                                     // retire in ar
        drain();
        drive_group(1'b1, i_instr(12'd4, 5'd1, 5'd11, `OPC_OP_IMM), 1'b0, '0, 0);
        drive_group(1'b1, i_instr(12'd5, 5'd1, 5'd11, `OPC_OP_IMM), 1'b0, '0, 0);
        idle(1);                                                     // stale id
        drive_group(1'b1, r_instr(5'd0, 5'd11, 5'd3), 1'b0, '0, 0);
        drain();
        u_checker.end_test("retire");

        for (int c = 0; c < 2000; c++) begin
            w0 = $random(seed);
            w1 = $random(seed);
            w0[6:0] = opcs[{$random(seed)} % 10];
            w1[6:0] = opcs[{$random(seed)} % 10];
            w0[11:7] = w0[11:7] & 5'h07;   // narrow reg range for more deps
            w1[11:7] = w1[11:7] & 5'h07;
            w1[19:15] = w1[19:15] & 5'h07;
            w1[24:20] = w1[24:20] & 5'h07;
            v0 = ({$random(seed)} % 4 != 0) && (inflight.size() < 26);
            drive_group(v0, w0, ({$random(seed)} % 2) != 0, w1, {$random(seed)} % 3);
        end
        drain();
        u_checker.end_test("soak");

        u_checker.report();
        if (u_checker.err_cnt == 0 && other_err == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // whole run limit
    initial begin
        #100000;
        $display("timeout: run did not finish in time");
        $display("Simulation failed");
        $finish;
    end

endmodule

/* rename.f */
+incdir+hdl
hdl/rename_pkg.sv
hdl/instr_decoder.sv
hdl/alias_table.sv
hdl/dep_resolver.sv
hdl/rename_top.sv
sim/rename_checker.sv
sim/rename_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the rename testbench with Verilator
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f rename.f \
    --top-module rename_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vrename_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi
exit 0
